// ==== Bender.yml ====
package:
  name: ccu_frontend

export_include_dirs:
  - .

sources:
  - files:
      - ccu_pkg.sv
      - ccu_shareable_demux.sv
      - ccu_rr_mux.sv
      - ccu_top.sv
  - target: simulation
    files:
      - tb_ccu_mem.sv
      - tb_ccu_top.sv

// ==== ccu_config.svh ====
// Coherent interconnect front end configuration
// Port count and field widths shared by the package and the top level

`ifndef CCU_CONFIG_SVH
`define CCU_CONFIG_SVH

// Number of cached master ports
`define CCU_NUM_PORTS 2

// Address and data widths of every port
`define CCU_ADDR_W 32
`define CCU_DATA_W 32

// ID width at the master ports
`define CCU_SLV_ID_W 4

// Stage mux output ID, widened by the master port index
`define CCU_STG_ID_W (`CCU_SLV_ID_W + $clog2(`CCU_NUM_PORTS))

// Memory port ID, widened by the memory mux input index
// The memory mux has one extra input for the coherent stage
`define CCU_MEM_ID_W (`CCU_STG_ID_W + $clog2(`CCU_NUM_PORTS + 1))

`endif

// ==== ccu_pkg.sv ====
// Coherent interconnect front end types
// Request and response layouts at the master, stage and memory levels

`include "ccu_config.svh"

package ccu_pkg;

  // Shareability domain carried with every request
  typedef enum logic [1:0] {
    NON_SHARE   = 2'd0,
    INNER_SHARE = 2'd1,
    OUTER_SHARE = 2'd2,
    SYSTEM      = 2'd3
  } domain_e;

  typedef logic [`CCU_SLV_ID_W-1:0] slv_id_t;
  typedef logic [`CCU_STG_ID_W-1:0] stg_id_t;
  typedef logic [`CCU_MEM_ID_W-1:0] mem_id_t;
  typedef logic [`CCU_ADDR_W-1:0]   addr_t;
  typedef logic [`CCU_DATA_W-1:0]   data_t;

  // Master port level
  typedef struct packed {
    logic    valid;
    slv_id_t id;
    addr_t   addr;
    logic    write;
    data_t   wdata; // Single beat, W folded in
    domain_e domain;
  } slv_req_t;

  typedef struct packed {
    logic        valid;
    slv_id_t     id;
    data_t       rdata;
    logic [1:0]  status;
  } slv_resp_t;

  // Stage level, behind the coherent mux
  typedef struct packed {
    logic    valid;
    stg_id_t id;
    addr_t   addr;
    logic    write;
    data_t   wdata;
    domain_e domain;
  } stg_req_t;

  typedef struct packed {
    logic        valid;
    stg_id_t     id;
    data_t       rdata;
    logic [1:0]  status;
  } stg_resp_t;

  // Memory port level
  typedef struct packed {
    logic    valid;
    mem_id_t id;
    addr_t   addr;
    logic    write;
    data_t   wdata;
    domain_e domain;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    mem_id_t     id;
    data_t       rdata;
    logic [1:0]  status;
  } mem_resp_t;

endpackage

// ==== ccu_rr_mux.sv ====
// Round-robin N-to-1 request mux with registered output
// Prepends the input index to the ID and routes responses back by it

`timescale 1ns/10ps

module ccu_rr_mux
  import ccu_pkg::*;
#(
  parameter int unsigned NumPorts = 2,
  parameter type in_req_t   = slv_req_t,
  parameter type in_resp_t  = slv_resp_t,
  parameter type out_req_t  = stg_req_t,
  parameter type out_resp_t = stg_resp_t
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  // Input side
  input  in_req_t  [NumPorts-1:0]   in_req_i,
  output logic     [NumPorts-1:0]   in_req_ready_o,
  output in_resp_t [NumPorts-1:0]   in_resp_o,
  input  logic     [NumPorts-1:0]   in_resp_ready_i,
  // Output side
  output out_req_t                  out_req_o,
  input  logic                      out_req_ready_i,
  input  out_resp_t                 out_resp_i,
  output logic                      out_resp_ready_o
);

  localparam int unsigned IdxW   = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int unsigned InIdW  = $bits(in_resp_o[0].id);
  localparam int unsigned OutIdW = $bits(out_resp_i.id);

  logic [NumPorts-1:0] in_valid;
  logic [NumPorts-1:0] gnt;
  logic [IdxW-1:0]     gnt_idx;
  logic                gnt_valid;
  logic [IdxW-1:0]     rr_q;     // First input to look at
  logic                load;
  logic                accept;
  out_req_t            out_d;
  out_req_t            out_q;
  logic [IdxW-1:0]     resp_idx;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_valid
    assign in_valid[i] = in_req_i[i].valid;
  end

  // Arbiter, scan upward from the pointer and wrap
  always_comb begin
    int unsigned idx;
    gnt       = '0;
    gnt_idx   = '0;
    gnt_valid = 1'b0;
    for (int unsigned k = 0; k < NumPorts; k++) begin
      idx = (rr_q + k) % NumPorts;
      if (!gnt_valid && in_valid[idx]) begin
        gnt[idx]  = 1'b1;
        gnt_idx   = idx[IdxW-1:0];
        gnt_valid = 1'b1;
      end
    end
  end

  // Register takes a new item when empty or draining this cycle
  assign load   = ~out_q.valid | out_req_ready_i;
  assign accept = load & gnt_valid;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_ready
    assign in_req_ready_o[i] = load & gnt[i];
  end

  // Winner payload with widened ID
  always_comb begin
    out_d.valid  = gnt_valid;
    out_d.id     = {gnt_idx, in_req_i[gnt_idx].id};
    out_d.addr   = in_req_i[gnt_idx].addr;
    out_d.write  = in_req_i[gnt_idx].write;
    out_d.wdata  = in_req_i[gnt_idx].wdata;
    out_d.domain = in_req_i[gnt_idx].domain;
  end

  // Pointer moves one past the accepted input
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (accept) begin
      if (gnt_idx == IdxW'(NumPorts - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= gnt_idx + 1'b1;
      end
    end
  end

  // Output register, only the valid bit is reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q.valid <= 1'b0;
    end else if (load) begin
      out_q <= out_d;
    end
  end

  assign out_req_o = out_q;

  // Response routing by the top ID bits
  assign resp_idx = out_resp_i.id[OutIdW-1 -: IdxW];

  always_comb begin
    out_resp_ready_o = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      in_resp_o[i].valid  = out_resp_i.valid && (resp_idx == IdxW'(i));
      in_resp_o[i].id     = out_resp_i.id[InIdW-1:0]; // Strip index
      in_resp_o[i].rdata  = out_resp_i.rdata;
      in_resp_o[i].status = out_resp_i.status;
      if (resp_idx == IdxW'(i)) begin
        out_resp_ready_o = in_resp_ready_i[i];
      end
    end
  end

  // A stalled output keeps its payload until the downstream takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_req_o.valid && !out_req_ready_i |=> out_req_o.valid && $stable(out_req_o))
    else $error("output payload changed while stalled");

  // Any pending input yields exactly one grant
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (|in_valid) |-> $onehot(gnt))
    else $error("grant not one-hot");

endmodule

// ==== ccu_shareable_demux.sv ====
// Shareability demux for one master port
// Sends domains 1 and 2 to the coherent path, the rest straight to memory

`timescale 1ns/10ps

module ccu_shareable_demux
  import ccu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Master side
  input  slv_req_t  slv_req_i,
  output logic      slv_req_ready_o,
  output slv_resp_t slv_resp_o,
  input  logic      slv_resp_ready_i,
  // Direct path to the memory mux
  output slv_req_t  dir_req_o,
  input  logic      dir_req_ready_i,
  // Coherent path to the stage mux
  output slv_req_t  coh_req_o,
  input  logic      coh_req_ready_i,
  input  slv_resp_t dir_resp_i,
  output logic      dir_resp_ready_o,
  input  slv_resp_t coh_resp_i,
  output logic      coh_resp_ready_o
);

  logic is_coh;

  // Inner and outer shareable need the coherency slot
  assign is_coh = (slv_req_i.domain == INNER_SHARE) ||
                  (slv_req_i.domain == OUTER_SHARE);

  // Request split
  always_comb begin
    dir_req_o       = slv_req_i;
    coh_req_o       = slv_req_i;
    dir_req_o.valid = slv_req_i.valid & ~is_coh;
    coh_req_o.valid = slv_req_i.valid &  is_coh;
  end

  // Ready comes from whichever path the domain selects
  assign slv_req_ready_o = is_coh ? coh_req_ready_i : dir_req_ready_i;

  // Response merge, direct path wins
  always_comb begin
    if (dir_resp_i.valid) begin
      slv_resp_o = dir_resp_i;
    end else begin
      slv_resp_o = coh_resp_i;
    end
  end

  assign dir_resp_ready_o = slv_resp_ready_i;
  assign coh_resp_ready_o = slv_resp_ready_i & ~dir_resp_i.valid; // Hold off while direct shown

  // A request belongs to one path only, for its whole lifetime
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(dir_req_o.valid && coh_req_o.valid))
    else $error("request valid on both paths");

endmodule

// ==== ccu_top.sv ====
// Coherency-aware interconnect front end
// Per-port shareability demux, coherent stage mux and memory mux

`timescale 1ns/10ps

`include "ccu_config.svh"

module ccu_top
  import ccu_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Cached masters
  input  slv_req_t  [`CCU_NUM_PORTS-1:0] slv_req_i,
  output logic      [`CCU_NUM_PORTS-1:0] slv_req_ready_o,
  output slv_resp_t [`CCU_NUM_PORTS-1:0] slv_resp_o,
  input  logic      [`CCU_NUM_PORTS-1:0] slv_resp_ready_i,
  // Memory port
  output mem_req_t                       mem_req_o,
  input  logic                           mem_req_ready_i,
  input  mem_resp_t                      mem_resp_i,
  output logic                           mem_resp_ready_o
);

  localparam int unsigned NumPorts = `CCU_NUM_PORTS;

  // Demux outputs
  slv_req_t  [NumPorts-1:0] dir_req;
  logic      [NumPorts-1:0] dir_req_ready;
  slv_resp_t [NumPorts-1:0] dir_resp;
  logic      [NumPorts-1:0] dir_resp_ready;
  slv_req_t  [NumPorts-1:0] coh_req;
  logic      [NumPorts-1:0] coh_req_ready;
  slv_resp_t [NumPorts-1:0] coh_resp;
  logic      [NumPorts-1:0] coh_resp_ready;

  // Coherent stage output, where a coherency controller would sit
  stg_req_t                 stg_req;
  logic                     stg_req_ready;
  stg_resp_t                stg_resp;
  logic                     stg_resp_ready;

  // Memory mux inputs, last one is the coherent stage
  stg_req_t  [NumPorts:0]   mem_in_req;
  logic      [NumPorts:0]   mem_in_req_ready;
  stg_resp_t [NumPorts:0]   mem_in_resp;
  logic      [NumPorts:0]   mem_in_resp_ready;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_port
    ccu_shareable_demux demux_inst (
      .clk_i,
      .rst_n_i,
      .slv_req_i        (slv_req_i[i]),
      .slv_req_ready_o  (slv_req_ready_o[i]),
      .slv_resp_o       (slv_resp_o[i]),
      .slv_resp_ready_i (slv_resp_ready_i[i]),
      .dir_req_o        (dir_req[i]),
      .dir_req_ready_i  (dir_req_ready[i]),
      .coh_req_o        (coh_req[i]),
      .coh_req_ready_i  (coh_req_ready[i]),
      .dir_resp_i       (dir_resp[i]),
      .dir_resp_ready_o (dir_resp_ready[i]),
      .coh_resp_i       (coh_resp[i]),
      .coh_resp_ready_o (coh_resp_ready[i])
    );

    // Direct path, master ID zero-extended to stage width
    assign mem_in_req[i] = '{valid:  dir_req[i].valid,
                             id:     stg_id_t'(dir_req[i].id),
                             addr:   dir_req[i].addr,
                             write:  dir_req[i].write,
                             wdata:  dir_req[i].wdata,
                             domain: dir_req[i].domain};
    assign dir_req_ready[i] = mem_in_req_ready[i];

    assign dir_resp[i] = '{valid:  mem_in_resp[i].valid,
                           id:     slv_id_t'(mem_in_resp[i].id),
                           rdata:  mem_in_resp[i].rdata,
                           status: mem_in_resp[i].status};
    assign mem_in_resp_ready[i] = dir_resp_ready[i];
  end

  ccu_rr_mux #(
    .NumPorts   (NumPorts),
    .in_req_t   (slv_req_t),
    .in_resp_t  (slv_resp_t),
    .out_req_t  (stg_req_t),
    .out_resp_t (stg_resp_t)
  ) stg_mux_inst (
    .clk_i,
    .rst_n_i,
    .in_req_i         (coh_req),
    .in_req_ready_o   (coh_req_ready),
    .in_resp_o        (coh_resp),
    .in_resp_ready_i  (coh_resp_ready),
    .out_req_o        (stg_req),
    .out_req_ready_i  (stg_req_ready),
    .out_resp_i       (stg_resp),
    .out_resp_ready_o (stg_resp_ready)
  );

  // Coherent stage joins the memory mux on the extra input
  assign mem_in_req[NumPorts]        = stg_req;
  assign stg_req_ready               = mem_in_req_ready[NumPorts];
  assign stg_resp                    = mem_in_resp[NumPorts];
  assign mem_in_resp_ready[NumPorts] = stg_resp_ready;

  ccu_rr_mux #(
    .NumPorts   (NumPorts + 1),
    .in_req_t   (stg_req_t),
    .in_resp_t  (stg_resp_t),
    .out_req_t  (mem_req_t),
    .out_resp_t (mem_resp_t)
  ) mem_mux_inst (
    .clk_i,
    .rst_n_i,
    .in_req_i         (mem_in_req),
    .in_req_ready_o   (mem_in_req_ready),
    .in_resp_o        (mem_in_resp),
    .in_resp_ready_i  (mem_in_resp_ready),
    .out_req_o        (mem_req_o),
    .out_req_ready_i  (mem_req_ready_i),
    .out_resp_i       (mem_resp_i),
    .out_resp_ready_o (mem_resp_ready_o)
  );

endmodule

// ==== sim.f ====
+incdir+.
ccu_pkg.sv
ccu_shareable_demux.sv
ccu_rr_mux.sv
ccu_top.sv
tb_ccu_mem.sv
tb_ccu_top.sv

// ==== tb_ccu_mem.sv ====
// Memory model for the interconnect testbench
// Stores writes and answers one request at a time, with optional back-pressure

`timescale 1ns/10ps

module tb_ccu_mem
  import ccu_pkg::*;
#(
  parameter int unsigned Depth = 256
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      stall_i,          // Holds request ready low
  input  mem_req_t  mem_req_i,
  output logic      mem_req_ready_o,
  output mem_resp_t mem_resp_o,
  input  logic      mem_resp_ready_i
);

  localparam int unsigned SlotW = $clog2(Depth);

  data_t            store_data [Depth];
  addr_t            store_addr [Depth];
  logic             store_vld  [Depth];
  mem_resp_t        resp_q;
  logic [SlotW-1:0] slot;

  // Word address picks the slot, the full address is kept as a tag
  assign slot            = mem_req_i.addr[SlotW+1:2];
  assign mem_req_ready_o = ~stall_i & ~resp_q.valid;
  assign mem_resp_o      = resp_q;

  // Unwritten words return a pattern built from the whole address
  function automatic data_t read_word(input addr_t addr, input logic [SlotW-1:0] s);
    if (store_vld[s] && store_addr[s] == addr) begin
      return store_data[s];
    end
    return data_t'(addr ^ 32'h5ca1_ab1e);
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_q <= '0;
      for (int i = 0; i < Depth; i++) begin
        store_vld[i] <= 1'b0;
      end
    end else begin
      if (resp_q.valid && mem_resp_ready_i) begin
        resp_q.valid <= 1'b0;
      end
      if (mem_req_i.valid && mem_req_ready_o) begin
        resp_q.valid  <= 1'b1;
        resp_q.id     <= mem_req_i.id;     // Echo the request ID
        resp_q.status <= 2'b00;
        resp_q.rdata  <= mem_req_i.write ? '0 : read_word(mem_req_i.addr, slot);
        if (mem_req_i.write) begin
          store_data[slot] <= mem_req_i.wdata;
          store_addr[slot] <= mem_req_i.addr;
          store_vld[slot]  <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== tb_ccu_top.sv ====
// Directed testbench for the coherency-aware interconnect front end
// Checks path routing, ID widening, response return and back-pressure on both sides

`timescale 1ns/10ps

`include "ccu_config.svh"

module tb_ccu_top
  import ccu_pkg::*;
;

  localparam int unsigned NUM_PORTS = `CCU_NUM_PORTS;
  localparam int unsigned TIMEOUT   = 200;

  logic                      clk;
  logic                      rst_n;
  slv_req_t  [NUM_PORTS-1:0] slv_req;
  logic      [NUM_PORTS-1:0] slv_req_ready;
  slv_resp_t [NUM_PORTS-1:0] slv_resp;
  logic      [NUM_PORTS-1:0] slv_resp_ready;
  mem_req_t                  mem_req;
  logic                      mem_req_ready;
  mem_resp_t                 mem_resp;
  logic                      mem_resp_ready;
  logic                      mem_stall;
  logic [31:0]               lfsr_state;

  mem_req_t                  mem_q [$];            // Accepted memory requests
  slv_resp_t                 resp_q [NUM_PORTS][$]; // Accepted responses per port

  ccu_top ccu_top_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .slv_req_i        (slv_req),
    .slv_req_ready_o  (slv_req_ready),
    .slv_resp_o       (slv_resp),
    .slv_resp_ready_i (slv_resp_ready),
    .mem_req_o        (mem_req),
    .mem_req_ready_i  (mem_req_ready),
    .mem_resp_i       (mem_resp),
    .mem_resp_ready_o (mem_resp_ready)
  );

  tb_ccu_mem mem_inst (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .stall_i          (mem_stall),
    .mem_req_i        (mem_req),
    .mem_req_ready_o  (mem_req_ready),
    .mem_resp_o       (mem_resp),
    .mem_resp_ready_i (mem_resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Transfers seen mid-cycle complete on the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (mem_req.valid && mem_req_ready) begin
        mem_q.push_back(mem_req);
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (slv_resp[p].valid && slv_resp_ready[p]) begin
          resp_q[p].push_back(slv_resp[p]);
        end
      end
    end
  end

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Low bits pick a distinct memory slot per test address
  function automatic addr_t rand_addr(input logic [7:0] slot);
    logic [31:0] hi;
    hi = rand_bits(22);
    return {hi[21:0], slot, 2'b00};
  endfunction

  function automatic slv_req_t make_req(input slv_id_t id, input addr_t addr,
                                        input logic write, input data_t wdata,
                                        input domain_e domain);
    slv_req_t r;
    r.valid  = 1'b1;
    r.id     = id;
    r.addr   = addr;
    r.write  = write;
    r.wdata  = wdata;
    r.domain = domain;
    return r;
  endfunction

  // Memory ID is the mux input index on top of the stage ID
  function automatic mem_req_t exp_mem(input slv_req_t r, input int unsigned port,
                                       input logic via_stage);
    mem_req_t    m;
    stg_id_t     sid;
    int unsigned in_idx;
    if (via_stage) begin
      sid    = (stg_id_t'(port) << `CCU_SLV_ID_W) | stg_id_t'(r.id);
      in_idx = NUM_PORTS;
    end else begin
      sid    = stg_id_t'(r.id);
      in_idx = port;
    end
    m.valid  = 1'b1;
    m.id     = (mem_id_t'(in_idx) << `CCU_STG_ID_W) | mem_id_t'(sid);
    m.addr   = r.addr;
    m.write  = r.write;
    m.wdata  = r.wdata;
    m.domain = r.domain;
    return m;
  endfunction

  function automatic slv_resp_t exp_resp(input slv_req_t r, input data_t rdata);
    slv_resp_t e;
    e.valid  = 1'b1;
    e.id     = r.id;
    e.rdata  = rdata;
    e.status = 2'b00;
    return e;
  endfunction

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run aborted at first error");
  endtask

  task automatic check_slv_resp(input string name, input slv_resp_t got, input slv_resp_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mem_req(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic send_req(input int unsigned p, input slv_req_t r);
    int unsigned t;
    @(posedge clk);
    slv_req[p] <= r;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!slv_req_ready[p] && t < TIMEOUT);
    if (!slv_req_ready[p]) begin
      $display("Timeout: request on port %0d was never accepted", p);
      abort_run();
    end
    @(posedge clk);
    slv_req[p] <= '0;
  endtask

  task automatic pop_mem(output mem_req_t m);
    int unsigned t;
    t = 0;
    while (mem_q.size() == 0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (mem_q.size() == 0) begin
      $display("Timeout: no request reached the memory port");
      abort_run();
    end else begin
      m = mem_q.pop_front();
    end
  endtask

  task automatic pop_resp(input int unsigned p, output slv_resp_t r);
    int unsigned t;
    t = 0;
    while (resp_q[p].size() == 0 && t < TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (resp_q[p].size() == 0) begin
      $display("Timeout: no response arrived on port %0d", p);
      abort_run();
    end else begin
      r = resp_q[p].pop_front();
    end
  endtask

  // Leftover items mean a response or request went astray
  task automatic expect_idle();
    repeat (4) @(negedge clk);
    if (mem_q.size() != 0) begin
      $display("Unexpected extra request on the memory port");
      abort_run();
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (resp_q[p].size() != 0) begin
        $display("Unexpected extra response on port %0d", p);
        abort_run();
      end
    end
  endtask

  task automatic run_txn(input int unsigned p, input slv_req_t r, input logic via_stage,
                         input data_t rdata);
    mem_req_t  got_m;
    slv_resp_t got_r;
    send_req(p, r);
    pop_mem(got_m);
    check_mem_req("mem_req_o", got_m, exp_mem(r, p, via_stage));
    pop_resp(p, got_r);
    check_slv_resp($sformatf("slv_resp_o[%0d]", p), got_r, exp_resp(r, rdata));
  endtask

  task automatic stalled_txn(input int unsigned p, input slv_req_t r, input logic via_stage,
                             input data_t rdata);
    mem_req_t    exp_m;
    mem_req_t    got_m;
    slv_resp_t   got_r;
    int unsigned hold;
    int unsigned t;
    exp_m = exp_mem(r, p, via_stage);
    hold  = rand_bits(3) + 2;
    @(posedge clk);
    mem_stall <= 1'b1;
    send_req(p, r);
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!mem_req.valid && t < TIMEOUT);
    if (!mem_req.valid) begin
      $display("Timeout: stalled request never showed on the memory port");
      abort_run();
    end
    repeat (hold) begin
      check_mem_req("mem_req_o", mem_req, exp_m); // Held while stalled
      @(negedge clk);
    end
    // Master refuses the response, so the memory side has to wait
    @(posedge clk);
    mem_stall         <= 1'b0;
    slv_resp_ready[p] <= 1'b0;
    pop_mem(got_m);
    check_mem_req("mem_req_o", got_m, exp_m);
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!mem_resp.valid && t < TIMEOUT);
    if (!mem_resp.valid) begin
      $display("Timeout: memory never answered the stalled request");
      abort_run();
    end
    repeat (2) begin
      check_flag("mem_resp_ready_o", mem_resp_ready, 1'b0);
      check_flag($sformatf("slv_resp_o[%0d].valid", p), slv_resp[p].valid, 1'b1);
      @(negedge clk);
    end
    @(posedge clk);
    slv_resp_ready[p] <= 1'b1;
    pop_resp(p, got_r);
    check_slv_resp($sformatf("slv_resp_o[%0d]", p), got_r, exp_resp(r, rdata));
  endtask

  task automatic test_reset_idle();
    repeat (3) begin
      @(negedge clk);
      check_flag("mem_req_o.valid", mem_req.valid, 1'b0);
      for (int p = 0; p < NUM_PORTS; p++) begin
        check_flag($sformatf("slv_resp_o[%0d].valid", p), slv_resp[p].valid, 1'b0);
      end
    end
  endtask

  task automatic test_direct_rw();
    slv_req_t wr;
    slv_req_t rd;
    wr = make_req(slv_id_t'(rand_bits(4)), rand_addr(8'h10), 1'b1, rand_bits(32), NON_SHARE);
    rd = make_req(slv_id_t'(rand_bits(4)), wr.addr, 1'b0, '0, NON_SHARE);
    run_txn(0, wr, 1'b0, '0);
    run_txn(0, rd, 1'b0, wr.wdata);
    expect_idle();
  endtask

  task automatic test_shareable_read();
    slv_req_t wr;
    slv_req_t rd;
    wr = make_req(slv_id_t'(rand_bits(4)), rand_addr(8'h21), 1'b1, rand_bits(32), NON_SHARE);
    run_txn(1, wr, 1'b0, '0);
    rd = make_req(slv_id_t'(rand_bits(4)), wr.addr, 1'b0, '0, INNER_SHARE);
    run_txn(1, rd, 1'b1, wr.wdata);
    rd.domain = OUTER_SHARE;
    rd.id     = slv_id_t'(rand_bits(4));
    run_txn(1, rd, 1'b1, wr.wdata);
    // System domain bypasses the coherent stage
    wr = make_req(slv_id_t'(rand_bits(4)), rand_addr(8'h22), 1'b1, rand_bits(32), SYSTEM);
    run_txn(1, wr, 1'b0, '0);
    rd = make_req(slv_id_t'(rand_bits(4)), wr.addr, 1'b0, '0, SYSTEM);
    run_txn(1, rd, 1'b0, wr.wdata);
    expect_idle();
  endtask

  // Port 0 sends shareable and port 1 direct in the same cycle
  task automatic concurrent_pair(input slv_req_t a, input slv_req_t b, input data_t rdata_a,
                                 input data_t rdata_b);
    mem_req_t  got_m;
    slv_resp_t got_r;
    fork
      send_req(0, a);
      send_req(1, b);
    join
    pop_mem(got_m); // Direct path is one cycle ahead of the coherent path
    check_mem_req("mem_req_o", got_m, exp_mem(b, 1, 1'b0));
    pop_mem(got_m);
    check_mem_req("mem_req_o", got_m, exp_mem(a, 0, 1'b1));
    pop_resp(0, got_r);
    check_slv_resp("slv_resp_o[0]", got_r, exp_resp(a, rdata_a));
    pop_resp(1, got_r);
    check_slv_resp("slv_resp_o[1]", got_r, exp_resp(b, rdata_b));
    expect_idle();
  endtask

  task automatic test_concurrent();
    slv_req_t wa;
    slv_req_t wb;
    slv_req_t ra;
    slv_req_t rb;
    wa = make_req(slv_id_t'(rand_bits(4)), rand_addr(8'h30), 1'b1, rand_bits(32), INNER_SHARE);
    wb = make_req(slv_id_t'(rand_bits(4)), rand_addr(8'h31), 1'b1, rand_bits(32), NON_SHARE);
    concurrent_pair(wa, wb, '0, '0);
    ra = make_req(slv_id_t'(rand_bits(4)), wa.addr, 1'b0, '0, OUTER_SHARE);
    rb = make_req(slv_id_t'(rand_bits(4)), wb.addr, 1'b0, '0, NON_SHARE);
    concurrent_pair(ra, rb, wa.wdata, wb.wdata);
  endtask

  task automatic test_backpressure();
    slv_req_t wr;
    slv_req_t rd;
    wr = make_req(slv_id_t'(rand_bits(4)), rand_addr(8'h50), 1'b1, rand_bits(32), NON_SHARE);
    rd = make_req(slv_id_t'(rand_bits(4)), wr.addr, 1'b0, '0, INNER_SHARE);
    stalled_txn(0, wr, 1'b0, '0);
    stalled_txn(1, rd, 1'b1, wr.wdata);
    expect_idle();
  endtask

  initial begin
    rst_n          = 1'b0;
    slv_req        = '0;
    slv_resp_ready = '1;
    mem_stall      = 1'b0;
    lfsr_state     = 32'hf988;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_idle();
    test_direct_rw();
    test_shareable_read();
    test_concurrent();
    test_backpressure();
    $display("TESTS PASSED");
    $finish;
  end

endmodule
